// File: logic/fetch_pkg.sv
package fetch_pkg;

    // fetch controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        REQ   = 3'd1,
        WAIT  = 3'd2,
        DRAIN = 3'd3,
        HOLD  = 3'd4
    } fetch_state_t;

    // exception code carried with each fetched entry
    typedef enum logic [2:0] {
        NONE         = 3'd0,
        ADEL         = 3'd1,
        TLBL_REFILL  = 3'd2,
        TLBL_INVALID = 3'd3,
        IBE          = 3'd4
    } fexc_t;

    // where a flush sends the next fetch
    typedef enum logic [1:0] {
        EXC    = 2'd0,
        REFILL = 2'd1,
        ERET   = 2'd2
    } redirect_t;

    // boot rom entry, kseg1
    localparam logic [31:0] RESET_VECTOR = 32'hbfc0_0000;

    // general exception entry with BEV set
    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

    // tlb refill entry with BEV set
    localparam logic [31:0] REFILL_VECTOR = 32'hbfc0_0200;

    // kseg0/kseg1 share this top pair, direct mapped
    localparam logic [1:0] UNMAPPED_SEG = 2'b10;

endpackage

// File: logic/pc_gen.sv
module pc_gen import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  logic        br_valid,
    input  logic [31:0] br_target,
    input  logic        flush,
    input  redirect_t   flush_kind,
    input  logic [31:0] epc,
    output logic [19:0] tlb_vpn,
    input  logic [19:0] tlb_pfn,
    input  logic        tlb_refill,
    input  logic        tlb_invalid,
    output logic [31:0] sram_addr,
    output logic [31:0] fetch_pc,
    output fexc_t       fetch_exc,
    output logic        issue_pc_ok
);

    // candidate pc for the next fetch
    logic [31:0] pc;
    // pc of the fetch already issued
    logic [31:0] req_pc;
    logic        pend_valid;
    logic [31:0] pend_target;
    logic [31:0] redirect_pc;
    logic        unmapped;

    always_comb begin
        case (flush_kind)
            REFILL:  redirect_pc = REFILL_VECTOR;
            EXC:     redirect_pc = EXC_VECTOR;
            default: redirect_pc = epc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (advance) begin
            // a branch seen in the issue cycle steers the next fetch
            if (br_valid) begin
                pc <= br_target;
            end else if (pend_valid) begin
                pc <= pend_target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // one pending branch, used by the next issue
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (flush || advance) begin
            pend_valid <= 1'b0;
        end else if (br_valid) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid) begin
            pend_target <= br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            req_pc <= pc;
        end
    end

    // a fault fetch loads in its own advance cycle
    assign fetch_pc = advance ? pc : req_pc;

    assign unmapped  = pc[31:30] == UNMAPPED_SEG;
    assign tlb_vpn   = pc[31:12];
    assign sram_addr = unmapped ? {3'b000, pc[28:0]} : {tlb_pfn, pc[11:0]};

    // alignment first, tlb result only for mapped pages
    always_comb begin
        if (pc[1:0] != 2'b00) begin
            fetch_exc = ADEL;
        end else if (!unmapped && tlb_refill) begin
            fetch_exc = TLBL_REFILL;
        end else if (!unmapped && tlb_invalid) begin
            fetch_exc = TLBL_INVALID;
        end else begin
            fetch_exc = NONE;
        end
    end

    assign issue_pc_ok = fetch_exc == NONE;

endmodule

// File: logic/fetch_ctrl.sv
module fetch_ctrl import fetch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  issue_pc_ok,
    input  fexc_t fetch_exc,
    output logic  sram_req,
    input  logic  sram_addr_ok,
    input  logic  sram_data_ok,
    input  logic  buf_free,
    input  logic  timed_out,
    output logic  advance,
    output logic  word_load,
    output fexc_t load_exc,
    output logic  timer_run,
    output logic  timer_clear
);

    fetch_state_t state;
    fetch_state_t next_state;
    logic         owed_after_flush;
    // data_ok still expected from the bus
    logic         owed;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        sram_req    = 1'b0;
        advance     = 1'b0;
        word_load   = 1'b0;
        load_exc    = NONE;
        timer_run   = 1'b0;
        timer_clear = 1'b0;
        case (state)
            IDLE: begin
                if (buf_free) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                if (issue_pc_ok) begin
                    sram_req = 1'b1;
                    if (sram_addr_ok) begin
                        advance     = 1'b1;
                        timer_clear = 1'b1;
                        next_state  = WAIT;
                    end
                end else begin
                    // fault fetch, no bus request
                    advance    = 1'b1;
                    word_load  = !flush;
                    load_exc   = fetch_exc;
                    next_state = HOLD;
                end
            end
            WAIT: begin
                if (sram_data_ok) begin
                    word_load  = !flush;
                    next_state = IDLE;
                end else if (timed_out) begin
                    // late data_ok still owed
                    word_load  = !flush;
                    load_exc   = IBE;
                    next_state = DRAIN;
                end else begin
                    timer_run = !flush;
                end
            end
            DRAIN: begin
                if (sram_data_ok) begin
                    next_state = IDLE;
                end
            end
            HOLD: begin
                // the faulting entry ends the stream until a redirect
                next_state = HOLD;
            end
            default: begin
                next_state = IDLE;
            end
        endcase

        // a data_ok in the flush cycle itself counts as drained
        owed_after_flush = ((state == WAIT || state == DRAIN) && !sram_data_ok)
                         || (sram_req && sram_addr_ok);
        if (flush) begin
            next_state = owed_after_flush ? DRAIN : REQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owed <= 1'b0;
        end else if (sram_req && sram_addr_ok) begin
            owed <= 1'b1;
        end else if (sram_data_ok) begin
            owed <= 1'b0;
        end
    end

    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        owed |-> !sram_req);

endmodule

// File: logic/fetch_wait_timer.sv
module fetch_wait_timer #(
    parameter int unsigned WAIT_LIMIT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic clear,
    output logic timed_out
);

    localparam int CW = $clog2(WAIT_LIMIT + 1);

    logic [CW-1:0] count;

    // saturates at the limit
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (run && count != CW'(WAIT_LIMIT)) begin
            count <= count + 1'b1;
        end
    end

    assign timed_out = count == CW'(WAIT_LIMIT);

    run_clear_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(clear && run));

endmodule

// File: logic/inst_buffer.sv
module inst_buffer import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        load,
    input  logic [31:0] load_word,
    input  logic [31:0] load_pc,
    input  fexc_t       load_exc,
    output logic        buf_free,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_word,
    output logic [31:0] inst_pc,
    output fexc_t       inst_exc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (flush) begin
            inst_valid <= 1'b0;
        end else if (load) begin
            inst_valid <= 1'b1;
        end else if (inst_ready) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            // faulted entries carry no word
            inst_word <= (load_exc == NONE) ? load_word : 32'd0;
            inst_pc   <= load_pc;
            inst_exc  <= load_exc;
        end
    end

    // empty, or handing its entry over this cycle
    assign buf_free = !inst_valid || inst_ready;

    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_ready && !flush |=>
            inst_valid && $stable(inst_word) && $stable(inst_pc) && $stable(inst_exc));

endmodule

// File: logic/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter int unsigned WAIT_LIMIT = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        br_valid,
    input  logic [31:0] br_target,
    input  logic        flush,
    input  redirect_t   flush_kind,
    input  logic [31:0] epc,
    output logic [19:0] tlb_vpn,
    input  logic [19:0] tlb_pfn,
    input  logic        tlb_refill,
    input  logic        tlb_invalid,
    output logic        sram_req,
    output logic [31:0] sram_addr,
    input  logic        sram_addr_ok,
    input  logic        sram_data_ok,
    input  logic [31:0] sram_rdata,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_word,
    output logic [31:0] inst_pc,
    output fexc_t       inst_exc
);

    logic        advance;
    logic        issue_pc_ok;
    logic [31:0] fetch_pc;
    fexc_t       fetch_exc;
    logic        buf_free;
    logic        word_load;
    fexc_t       load_exc;
    logic        timer_run;
    logic        timer_clear;
    logic        timed_out;

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .br_valid    (br_valid),
        .br_target   (br_target),
        .flush       (flush),
        .flush_kind  (flush_kind),
        .epc         (epc),
        .tlb_vpn     (tlb_vpn),
        .tlb_pfn     (tlb_pfn),
        .tlb_refill  (tlb_refill),
        .tlb_invalid (tlb_invalid),
        .sram_addr   (sram_addr),
        .fetch_pc    (fetch_pc),
        .fetch_exc   (fetch_exc),
        .issue_pc_ok (issue_pc_ok)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_pc_ok  (issue_pc_ok),
        .fetch_exc    (fetch_exc),
        .sram_req     (sram_req),
        .sram_addr_ok (sram_addr_ok),
        .sram_data_ok (sram_data_ok),
        .buf_free     (buf_free),
        .timed_out    (timed_out),
        .advance      (advance),
        .word_load    (word_load),
        .load_exc     (load_exc),
        .timer_run    (timer_run),
        .timer_clear  (timer_clear)
    );

    fetch_wait_timer #(
        .WAIT_LIMIT (WAIT_LIMIT)
    ) u_wait_timer (
        .clk       (clk),
        .reset     (reset),
        .run       (timer_run),
        .clear     (timer_clear),
        .timed_out (timed_out)
    );

    inst_buffer u_inst_buffer (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .load       (word_load),
        .load_word  (sram_rdata),
        .load_pc    (fetch_pc),
        .load_exc   (load_exc),
        .buf_free   (buf_free),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_word  (inst_word),
        .inst_pc    (inst_pc),
        .inst_exc   (inst_exc)
    );

endmodule

// File: tests/fetch_mem_model.sv
module fetch_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        mute,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int          seed = 99;
    logic        pending = 1'b0;
    logic [31:0] held_addr = 32'd0;
    int          addr_wait = 0;
    int          data_wait = 0;

    // memory contents, a hash of the whole physical address
    function automatic logic [31:0] word_hash(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = 32'd0;
    end

    // outputs change on the falling edge only
    always @(negedge clk) begin
        if (reset) begin
            addr_ok   <= 1'b0;
            data_ok   <= 1'b0;
            pending   = 1'b0;
            addr_wait = $unsigned($random(seed)) % 4;
        end else begin
            data_ok <= 1'b0;
            if (addr_ok) begin
                // taken at the last rising edge
                addr_ok   <= 1'b0;
                pending   = 1'b1;
                data_wait = $unsigned($random(seed)) % 4;
            end else if (pending) begin
                if (data_wait > 0) begin
                    data_wait--;
                end else if (!mute) begin
                    data_ok <= 1'b1;
                    rdata   <= word_hash(held_addr);
                    pending = 1'b0;
                end
            end else if (req) begin
                if (addr_wait > 0) begin
                    addr_wait--;
                end else begin
                    addr_ok   <= 1'b1;
                    held_addr = addr;
                    addr_wait = $unsigned($random(seed)) % 4;
                end
            end
        end
    end

endmodule

// File: tests/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 8;
    localparam int WAIT_LIMIT     = 16;
    // deliveries awaited by the sequence below
    localparam int EXPECTED_INSTS = 8 + 3 * 4 + 3 * 3 + 4 + 4 + 3 + 1 + 4;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] paddr;
        logic [31:0] word;
        fexc_t       exc;
    } fetch_ref_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        br_valid;
    logic [31:0] br_target;
    logic        flush;
    redirect_t   flush_kind;
    logic [31:0] epc;
    logic [19:0] tlb_vpn;
    logic [19:0] tlb_pfn;
    logic        tlb_refill;
    logic        tlb_invalid;
    logic        sram_req;
    logic [31:0] sram_addr;
    logic        sram_addr_ok;
    logic        sram_data_ok;
    logic [31:0] sram_rdata;
    logic        inst_valid;
    logic        inst_ready = 1'b0;
    logic [31:0] inst_word;
    logic [31:0] inst_pc;
    fexc_t       inst_exc;
    logic        mute;
    logic        stall_decode;
    int          seed = 99;
    fetch_ref_t  exp_q[$];
    fetch_ref_t  head;
    fetch_ref_t  ref_fetch;
    logic [31:0] exp_pc;
    logic        pend_valid;
    logic [31:0] pend_target;
    logic        halted;
    logic        ibe_seen = 1'b0;
    int          delivered = 0;

    fetch_top #(.WAIT_LIMIT(WAIT_LIMIT)) DUT (.*);

    fetch_mem_model u_mem (
        .clk     (clk),
        .reset   (reset),
        .mute    (mute),
        .req     (sram_req),
        .addr    (sram_addr),
        .addr_ok (sram_addr_ok),
        .data_ok (sram_data_ok),
        .rdata   (sram_rdata)
    );

    // tlb model with pfn = vpn ^ 0x55
    // vpn bit 4 gives a refill and bit 5 an invalid entry
    assign tlb_pfn     = tlb_vpn ^ 20'h00055;
    assign tlb_refill  = tlb_vpn[4];
    assign tlb_invalid = tlb_vpn[5];

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] word_hash(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic fetch_ref_t expected_fetch(input logic [31:0] pc);
        fetch_ref_t r;
        logic       mapped;
        mapped  = pc[31:30] != UNMAPPED_SEG;
        r.pc    = pc;
        r.paddr = mapped ? {pc[31:12] ^ 20'h00055, pc[11:0]} : {3'b000, pc[28:0]};
        // alignment wins over the tlb
        // pc[16] and pc[17] are vpn bits 4 and 5
        if (pc[1:0] != 2'b00)
            r.exc = ADEL;
        else if (mapped && pc[16])
            r.exc = TLBL_REFILL;
        else if (mapped && pc[17])
            r.exc = TLBL_INVALID;
        else
            r.exc = NONE;
        r.word = (r.exc == NONE) ? word_hash(r.paddr) : 32'd0;
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_exc(input string name, input fexc_t got, input fexc_t exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %s, expected %s",
                                $time, name, got.name(), exp.name()));
    endtask

    // a faulting candidate is fetched without a bus request and ends the stream
    task automatic queue_fault_fetch();
        ref_fetch = expected_fetch(exp_pc);
        if (ref_fetch.exc != NONE) begin
            exp_q.push_back(ref_fetch);
            halted = 1'b1;
        end
    endtask

    // sampled just after the falling edge
    // these values hold until the next rising edge
    always begin
        @(negedge clk);
        #1;
        if (reset) begin
            exp_q.delete();
            exp_pc     = RESET_VECTOR;
            pend_valid = 1'b0;
            halted     = 1'b0;
        end else begin
            if (halted && sram_req)
                abort_run("SRAM request issued after a fault fetch ended the stream");
            if (inst_valid && inst_ready && !flush) begin
                if (exp_q.size() == 0) begin
                    abort_run("instruction handed to decode with no fetch outstanding");
                end else begin
                    head = exp_q.pop_front();
                    check_pc("inst_pc", inst_pc, head.pc);
                    check_exc("inst_exc", inst_exc, head.exc);
                    check_word("inst_word", inst_word, head.word);
                    if (head.exc == IBE)
                        ibe_seen = 1'b1;
                    delivered++;
                end
            end
            if (flush) begin
                exp_q.delete();
                pend_valid = 1'b0;
                halted     = 1'b0;
                case (flush_kind)
                    REFILL:  exp_pc = REFILL_VECTOR;
                    EXC:     exp_pc = EXC_VECTOR;
                    default: exp_pc = epc;
                endcase
                queue_fault_fetch();
            end else if (!halted && sram_req && sram_addr_ok) begin
                ref_fetch = expected_fetch(exp_pc);
                check_pc("sram_addr", sram_addr, ref_fetch.paddr);
                if (mute) begin
                    ref_fetch.exc  = IBE;
                    ref_fetch.word = 32'd0;
                end
                exp_q.push_back(ref_fetch);
                // this fetch is the delay slot and a branch target comes next
                if (br_valid)
                    exp_pc = br_target;
                else if (pend_valid)
                    exp_pc = pend_target;
                else
                    exp_pc = exp_pc + 32'd4;
                pend_valid = 1'b0;
                queue_fault_fetch();
            end else if (br_valid) begin
                pend_valid  = 1'b1;
                pend_target = br_target;
            end
        end
    end

    // decode back-pressure
    always @(negedge clk) begin
        inst_ready <= stall_decode ? 1'b0 : (($random(seed) & 3) != 0);
    end

    task automatic wait_delivered(input int n);
        int target;
        target = delivered + n;
        while (delivered < target)
            @(negedge clk);
    endtask

    task automatic pulse_branch(input logic [31:0] target);
        @(negedge clk);
        br_valid  = 1'b1;
        br_target = target;
        @(negedge clk);
        br_valid  = 1'b0;
    endtask

    task automatic redirect_now(input redirect_t kind, input logic [31:0] target_epc);
        @(negedge clk);
        flush      = 1'b1;
        flush_kind = kind;
        epc        = target_epc;
        @(negedge clk);
        flush      = 1'b0;
    endtask

    // lands the flush on the cycle after a request is taken
    task automatic flush_in_wait(input redirect_t kind, input logic [31:0] target_epc);
        do begin
            @(negedge clk);
            #1;
        end while (!(sram_req && sram_addr_ok));
        redirect_now(kind, target_epc);
    endtask

    task automatic check_bus_timeout();
        int waited;
        stall_decode = 1'b1;
        waited       = 0;
        // a held entry under stall leaves nothing in flight
        do begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT + 40)
                abort_run("decode stall never left an instruction held in the buffer");
        end while (!(inst_valid && !inst_ready));
        @(negedge clk);
        mute         = 1'b1;
        stall_decode = 1'b0;
        waited       = 0;
        while (!ibe_seen) begin
            if (waited > WAIT_LIMIT + 40)
                abort_run("no bus error delivered after the data_ok timeout");
            @(negedge clk);
            waited++;
        end
        mute = 1'b0;
    endtask

    initial begin
        logic [31:0] branch_to;
        reset        = 1'b1;
        br_valid     = 1'b0;
        br_target    = 32'd0;
        flush        = 1'b0;
        flush_kind   = EXC;
        epc          = 32'd0;
        mute         = 1'b0;
        stall_decode = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        wait_delivered(8);
        branch_to = 32'hbfc0_1000;
        repeat (3) begin
            repeat ($unsigned($random(seed)) % 6) @(negedge clk);
            pulse_branch(branch_to);
            wait_delivered(4);
            branch_to = branch_to + 32'h0000_0100;
        end
        flush_in_wait(EXC, 32'd0);
        wait_delivered(3);
        flush_in_wait(REFILL, 32'd0);
        wait_delivered(3);
        flush_in_wait(ERET, 32'hbfc0_2000);
        wait_delivered(3);
        // mapped page followed by refill, invalid and two misaligned pcs
        redirect_now(ERET, 32'h0040_0000);
        wait_delivered(4);
        redirect_now(ERET, 32'h0001_0000);
        wait_delivered(1);
        redirect_now(ERET, 32'h0002_0000);
        wait_delivered(1);
        redirect_now(ERET, 32'h0001_0002);
        wait_delivered(1);
        redirect_now(ERET, 32'hbfc0_0006);
        wait_delivered(1);
        redirect_now(EXC, 32'd0);
        wait_delivered(3);
        check_bus_timeout();
        wait_delivered(4);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 40 * EXPECTED_INSTS));
        abort_run("watchdog expired before the test sequence finished");
    end

endmodule

// File: filelist.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/fetch_ctrl.sv
logic/fetch_wait_timer.sv
logic/inst_buffer.sv
logic/fetch_top.sv
tests/fetch_mem_model.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator, judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f filelist.f -o fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
